// File: flist.f
verilog/cache_geom_pkg.sv
verilog/fetch_if_pkg.sv
verilog/sdp_ram.sv
verilog/icache_way.sv
verilog/icache.sv
verilog/icache_mem_bridge.sv
verilog/icache_top.sv
verif/mem_model.sv
verif/tb_icache.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache \
    -f flist.f \
    -o sim_icache

./obj_dir/sim_icache | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: testbench reported success"
    exit 0
else
    echo "run_sim: testbench reported failure"
    exit 1
fi

// File: verif/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_if_pkg::mem_rd_t mem_rd_i,
    output logic                  mem_ack_o,
    output logic                  beat_valid_o,
    output logic [31:0]           beat_data_o
);
    import fetch_if_pkg::*;

    logic [31:0] addr;
    int          len;

    function automatic logic [31:0] word_at(logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    // all outputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        mem_ack_o    = 1'b0;
        beat_valid_o = 1'b0;
        beat_data_o  = '0;
        forever begin
            next_cycle();
            if (!reset && mem_rd_i.valid) begin
                addr = mem_rd_i.addr;
                len  = int'(mem_rd_i.len);
                repeat ($urandom_range(3, 0)) next_cycle();
                mem_ack_o = 1'b1;
                next_cycle();
                mem_ack_o = 1'b0;
                // beats in address order, with random gaps
                for (int i = 0; i <= len; i++) begin
                    repeat ($urandom_range(2, 0)) next_cycle();
                    beat_valid_o = 1'b1;
                    beat_data_o  = word_at(addr + 32'(4 * i));
                    next_cycle();
                    beat_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import cache_geom_pkg::*;
    import fetch_if_pkg::*;

    localparam int timeout_cycles = 400;

    localparam logic [31:0] pc_a = 32'h0001_00a0;
    localparam logic [31:0] pc_b = 32'h0002_00a0;
    localparam logic [31:0] pc_c = 32'h0003_00a0;
    localparam logic [31:0] pc_x = 32'h0004_0100;
    localparam logic [31:0] pc_y = 32'h0005_0140;

    // one accepted fetch still owed a response
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] cyc;
        logic        fast;
    } pending_t;

    logic        clk;
    logic        reset;
    logic        flush;
    fetch_req_t  fetch_req;
    logic        stall;
    fetch_resp_t fetch_resp;
    cacop_t      cacop;
    mem_rd_t     mem_rd;
    logic        mem_ack;
    logic        beat_valid;
    logic [31:0] beat_data;

    pending_t    pend [$];
    logic [31:0] cycle;
    int          errors;
    int          req_count;
    int          base;
    logic [2:0]  last_len;
    logic [31:0] last_addr;

    icache_top #(
        .num_ways (2)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush),
        .fetch_req_i  (fetch_req),
        .stall_o      (stall),
        .fetch_resp_o (fetch_resp),
        .cacop_i      (cacop),
        .mem_rd_o     (mem_rd),
        .mem_ack_i    (mem_ack),
        .beat_valid_i (beat_valid),
        .beat_data_i  (beat_data)
    );

    mem_model u_mem (
        .clk          (clk),
        .reset        (reset),
        .mem_rd_i     (mem_rd),
        .mem_ack_o    (mem_ack),
        .beat_valid_o (beat_valid),
        .beat_data_o  (beat_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    function automatic logic [31:0] expected_inst(logic [31:0] pc);
        return pc ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("tb_icache: %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic give_up(string what);
        $display("timeout at %0t: %s", $time, what);
        errors++;
        finish_run();
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic fetch(logic [31:0] pc, logic uncached, logic fast);
        int       waited;
        pending_t p;
        waited             = 0;
        fetch_req.valid    = 1'b1;
        fetch_req.pc       = pc;
        fetch_req.uncached = uncached;
        @(negedge clk);
        while (stall) begin
            waited++;
            if (waited > timeout_cycles) begin
                give_up($sformatf("fetch of pc %h was never accepted", pc));
            end
            @(negedge clk);
        end
        p.pc   = pc;
        p.cyc  = cycle;
        p.fast = fast;
        pend.push_back(p);
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(posedge clk);
        while (pend.size() != 0) begin
            waited++;
            if (waited > timeout_cycles) begin
                give_up("responses still missing");
            end
            @(posedge clk);
        end
        #1;
    endtask

    task automatic do_cacop(logic [1:0] mode, logic [31:0] addr);
        cacop.en   = 1'b1;
        cacop.mode = mode;
        cacop.addr = addr;
        @(posedge clk);
        #1;
        cacop.en = 1'b0;
    endtask

    task automatic expect_requests(int n, string what);
        check_value(what, 32'(req_count - base), 32'(n));
        base = req_count;
    endtask

    // in-order response check plus memory request count
    always @(negedge clk) begin : monitor
        pending_t p;
        if (!reset && mem_rd.valid && mem_ack) begin
            req_count++;
            last_len  = mem_rd.len;
            last_addr = mem_rd.addr;
        end
        if (!reset && fetch_resp.valid) begin
            if (pend.size() == 0) begin
                $display("error at %0t: response for pc %h with no fetch outstanding",
                         $time, fetch_resp.pc);
                errors++;
            end else begin
                p = pend.pop_front();
                check_value("fetch_resp.pc", fetch_resp.pc, p.pc);
                check_value("fetch_resp.inst", fetch_resp.inst, expected_inst(p.pc));
                if (p.fast) begin
                    check_value("hit latency", cycle - p.cyc, 32'd1);
                end
            end
        end
    end

    initial begin
        int          waited;
        logic [31:0] rnd_pc;
        logic        rnd_unc;
        void'($urandom(56));
        reset     = 1'b1;
        flush     = 1'b0;
        fetch_req = '0;
        cacop     = '0;
        errors    = 0;
        req_count = 0;
        base      = 0;
        last_len  = '0;
        last_addr = '0;
        repeat (10) @(posedge clk);
        #1;
        check_value("stall_o", 32'(stall), 32'd1);
        check_value("fetch_resp.valid", 32'(fetch_resp.valid), 32'd0);
        check_value("mem_rd.valid", 32'(mem_rd.valid), 32'd0);
        reset = 1'b0;

        // cold line, then every word of it back to back
        fetch(32'h0000_1040, 1'b0, 1'b0);
        wait_idle();
        expect_requests(1, "cold miss request count");
        check_value("mem_rd.addr", last_addr, 32'h0000_1040);
        check_value("mem_rd.len", 32'(last_len), 32'd7);
        for (int i = 0; i < 8; i++) begin
            fetch(32'h0000_1040 + 32'(4 * i), 1'b0, 1'b1);
        end
        wait_idle();
        expect_requests(0, "hit request count");

        // uncached goes out every time
        repeat (2) begin
            fetch(32'h0000_1048, 1'b1, 1'b0);
            wait_idle();
            expect_requests(1, "uncached request count");
            check_value("mem_rd.addr", last_addr, 32'h0000_1048);
            check_value("mem_rd.len", 32'(last_len), 32'd0);
        end

        do_cacop(2'd0, 32'h0000_1040);
        fetch(32'h0000_1044, 1'b0, 1'b0);
        wait_idle();
        expect_requests(1, "request count after invalidate");
        // mode 3 leaves the line alone
        do_cacop(2'd3, 32'h0000_1040);
        fetch(32'h0000_1044, 1'b0, 1'b1);
        wait_idle();
        expect_requests(0, "request count after ignored cacop");

        // lru at one index
        fetch(pc_a, 1'b0, 1'b0);
        fetch(pc_b, 1'b0, 1'b0);
        fetch(pc_a, 1'b0, 1'b0);
        fetch(pc_c, 1'b0, 1'b0);
        wait_idle();
        expect_requests(3, "lru fill request count");
        fetch(pc_a, 1'b0, 1'b1);
        wait_idle();
        expect_requests(0, "lru kept line request count");
        fetch(pc_b, 1'b0, 1'b0);
        wait_idle();
        expect_requests(1, "lru victim request count");

        // flush while x waits for its line
        fetch(pc_x, 1'b0, 1'b0);
        waited = 0;
        @(negedge clk);
        while (!mem_rd.valid) begin
            waited++;
            if (waited > timeout_cycles) begin
                give_up("miss never reached the memory bus");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        flush = 1'b1;
        // x is owed nothing once flushed
        pend.delete(pend.size() - 1);
        fetch(pc_y, 1'b0, 1'b0);
        flush = 1'b0;
        wait_idle();
        expect_requests(2, "flush request count");
        fetch(pc_x, 1'b0, 1'b0);
        wait_idle();
        expect_requests(1, "refetch after flush request count");

        for (int i = 0; i < 40; i++) begin
            rnd_pc  = 32'h0006_0000;
            rnd_pc  = rnd_pc | ($urandom_range(3, 0) << 12);
            rnd_pc  = rnd_pc | ($urandom_range(3, 0) << 5);
            rnd_pc  = rnd_pc | ($urandom_range(7, 0) << 2);
            rnd_unc = ($urandom_range(7, 0) == 0);
            fetch(rnd_pc, rnd_unc, 1'b0);
        end
        wait_idle();

        finish_run();
    end

endmodule

`default_nettype wire

// File: verilog/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int tag_w    = 20;
    localparam int index_w  = 7;
    localparam int offset_w = 5;
    localparam int bank_num = 8;
    localparam int set_num  = 128;

    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [index_w-1:0] index_t;

    // one tag array entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    // word i of a line sits in bank i
    typedef logic [bank_num-1:0][31:0] line_t;

    function automatic tag_t addr_tag(logic [31:0] addr);
        return addr[31 -: tag_w];
    endfunction

    function automatic index_t addr_index(logic [31:0] addr);
        return addr[offset_w +: index_w];
    endfunction

    function automatic logic [$clog2(bank_num)-1:0] addr_word(logic [31:0] addr);
        return addr[2 +: $clog2(bank_num)];
    endfunction

endpackage

`default_nettype wire

// File: verilog/fetch_if_pkg.sv
`default_nettype none

package fetch_if_pkg;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        uncached;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_resp_t;

    // modes 0 to 2 invalidate the index in all ways
    typedef struct packed {
        logic        en;
        logic [1:0]  mode;
        logic [31:0] addr;
    } cacop_t;

    // line clear means a single uncached word
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic        line;
    } refill_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [2:0]  len;
    } mem_rd_t;

endpackage

`default_nettype wire

// File: verilog/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int num_ways = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush_i,
    input  fetch_if_pkg::fetch_req_t  fetch_req_i,
    output logic                      stall_o,
    output fetch_if_pkg::fetch_resp_t fetch_resp_o,
    input  fetch_if_pkg::cacop_t      cacop_i,
    output fetch_if_pkg::refill_req_t refill_o,
    input  cache_geom_pkg::line_t     refill_line_i,
    input  logic                      refill_done_i
);
    import cache_geom_pkg::*;
    import fetch_if_pkg::*;

    localparam int way_w = (num_ways > 1) ? $clog2(num_ways) : 1;

    fetch_req_t                    s2_q;
    refill_req_t                   refill_q;
    logic                          ignore_q;
    logic                          ready_q;
    logic                          cacop_q;
    logic [set_num-1:0][way_w-1:0] lru_q;

    logic [num_ways-1:0]           hit_vec;
    logic [31:0]                   way_word [num_ways];
    logic [num_ways-1:0]           way_we;
    logic [way_w-1:0]              hit_way;
    logic [31:0]                   hit_word;
    logic [way_w-1:0]              lru_pick;
    index_t                        s2_index;
    tag_t                          s2_tag;
    logic [$clog2(bank_num)-1:0]   s2_word;
    index_t                        rd_index;
    index_t                        wr_index;
    tagv_t                         wr_tagv;
    logic                          s2_hit;
    logic                          s2_wait;
    logic                          fill_ok;
    logic                          resp_fire;
    logic                          line_fill;
    logic                          cacop_inv;
    logic                          accept;

    function automatic logic [way_w-1:0] next_way(logic [way_w-1:0] w);
        return (w == way_w'(num_ways - 1)) ? '0 : w + 1'b1;
    endfunction

    assign s2_index = addr_index(s2_q.pc);
    assign s2_tag   = addr_tag(s2_q.pc);
    assign s2_word  = addr_word(s2_q.pc);
    assign lru_pick = lru_q[s2_index];

    assign s2_hit  = s2_q.valid && !s2_q.uncached && (|hit_vec);
    assign s2_wait = s2_q.valid && !s2_hit;
    // a reply after a flush belongs to nobody
    assign fill_ok = refill_done_i && refill_q.valid && !ignore_q;

    assign stall_o = !flush_i && (!ready_q || s2_wait || cacop_i.en || cacop_q);
    assign accept  = fetch_req_i.valid && !stall_o;

    // keep reading the waiting index while stalled
    assign rd_index = stall_o ? s2_index : addr_index(fetch_req_i.pc);

    assign resp_fire = !flush_i && (s2_hit || (s2_q.valid && fill_ok));
    assign line_fill = resp_fire && !s2_hit && !s2_q.uncached;

    always_comb begin
        hit_way  = '0;
        hit_word = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w]) begin
                hit_way  = way_w'(w);
                hit_word = way_word[w];
            end
        end
    end

    always_comb begin
        fetch_resp_o.valid = resp_fire;
        fetch_resp_o.pc    = s2_q.pc;
        if (s2_hit) begin
            fetch_resp_o.inst = hit_word;
        end else if (s2_q.uncached) begin
            fetch_resp_o.inst = refill_line_i[0];
        end else begin
            fetch_resp_o.inst = refill_line_i[s2_word];
        end
    end

    // invalidate takes the write port over a fill
    assign cacop_inv = cacop_i.en && (cacop_i.mode != 2'd3);
    assign wr_index  = cacop_inv ? addr_index(cacop_i.addr) : s2_index;

    always_comb begin
        wr_tagv.valid = !cacop_inv;
        wr_tagv.tag   = cacop_inv ? '0 : s2_tag;
        for (int w = 0; w < num_ways; w++) begin
            way_we[w] = cacop_inv || (line_fill && (lru_pick == way_w'(w)));
        end
    end

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        icache_way u_way (
            .clk        (clk),
            .reset      (reset),
            .raddr_i    (rd_index),
            .tag_i      (s2_tag),
            .we_i       (way_we[w]),
            .waddr_i    (wr_index),
            .line_i     (refill_line_i),
            .tagv_i     (wr_tagv),
            .word_sel_i (s2_word),
            .hit_o      (hit_vec[w]),
            .word_o     (way_word[w])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q    <= 1'b0;
            cacop_q    <= 1'b0;
            s2_q.valid <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            cacop_q <= cacop_i.en;
            if (accept) begin
                s2_q <= fetch_req_i;
            end else if (flush_i || resp_fire) begin
                s2_q.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            refill_q.valid <= 1'b0;
            ignore_q       <= 1'b0;
        end else if (refill_done_i) begin
            refill_q.valid <= 1'b0;
            ignore_q       <= 1'b0;
        end else begin
            if (flush_i && refill_q.valid) begin
                ignore_q <= 1'b1;
            end
            if (s2_wait && !refill_q.valid && !flush_i) begin
                refill_q.valid <= 1'b1;
                refill_q.addr  <= s2_q.pc;
                refill_q.line  <= !s2_q.uncached;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (resp_fire && s2_hit) begin
            lru_q[s2_index] <= next_way(hit_way);
        end else if (line_fill) begin
            lru_q[s2_index] <= next_way(lru_pick);
        end
    end

    assign refill_o = refill_q;

    a_one_hit: assert property (@(posedge clk) disable iff (reset)
        s2_q.valid |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// File: verilog/icache_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem_bridge (
    input  logic                      clk,
    input  logic                      reset,
    input  fetch_if_pkg::refill_req_t refill_i,
    output cache_geom_pkg::line_t     refill_line_o,
    output logic                      refill_done_o,
    output fetch_if_pkg::mem_rd_t     mem_rd_o,
    input  logic                      mem_ack_i,
    input  logic                      beat_valid_i,
    input  logic [31:0]               beat_data_i
);
    import cache_geom_pkg::*;
    import fetch_if_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_collect
    } state_t;

    state_t     state_q;
    mem_rd_t    rd_q;
    line_t      line_q;
    logic [2:0] beat_q;
    logic       done_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= st_idle;
            rd_q.valid <= 1'b0;
            beat_q     <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    // request is still up in the done cycle
                    if (refill_i.valid && !done_q) begin
                        rd_q.valid <= 1'b1;
                        if (refill_i.line) begin
                            rd_q.addr <= {refill_i.addr[31:offset_w], {offset_w{1'b0}}};
                            rd_q.len  <= 3'(bank_num - 1);
                        end else begin
                            rd_q.addr <= {refill_i.addr[31:2], 2'b00};
                            rd_q.len  <= 3'd0;
                        end
                        beat_q  <= '0;
                        state_q <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (mem_ack_i) begin
                        rd_q.valid <= 1'b0;
                        state_q    <= st_collect;
                    end
                end
                st_collect: begin
                    if (beat_valid_i) begin
                        beat_q <= beat_q + 3'd1;
                        if (beat_q == rd_q.len) begin
                            state_q <= st_idle;
                            done_q  <= 1'b1;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // beats land in address order, a lone word in lane zero
    always_ff @(posedge clk) begin
        if (state_q == st_collect && beat_valid_i) begin
            line_q[beat_q] <= beat_data_i;
        end
    end

    assign mem_rd_o      = rd_q;
    assign refill_line_o = line_q;
    assign refill_done_o = done_q;

    a_beat_in_burst: assert property (@(posedge clk) disable iff (reset)
        beat_valid_i |-> state_q == st_collect);

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int num_ways = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush_i,
    input  fetch_if_pkg::fetch_req_t  fetch_req_i,
    output logic                      stall_o,
    output fetch_if_pkg::fetch_resp_t fetch_resp_o,
    input  fetch_if_pkg::cacop_t      cacop_i,
    output fetch_if_pkg::mem_rd_t     mem_rd_o,
    input  logic                      mem_ack_i,
    input  logic                      beat_valid_i,
    input  logic [31:0]               beat_data_i
);
    import cache_geom_pkg::*;
    import fetch_if_pkg::*;

    refill_req_t refill_req;
    line_t       refill_line;
    logic        refill_done;

    icache #(
        .num_ways (num_ways)
    ) u_icache (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush_i),
        .fetch_req_i   (fetch_req_i),
        .stall_o       (stall_o),
        .fetch_resp_o  (fetch_resp_o),
        .cacop_i       (cacop_i),
        .refill_o      (refill_req),
        .refill_line_i (refill_line),
        .refill_done_i (refill_done)
    );

    icache_mem_bridge u_bridge (
        .clk           (clk),
        .reset         (reset),
        .refill_i      (refill_req),
        .refill_line_o (refill_line),
        .refill_done_o (refill_done),
        .mem_rd_o      (mem_rd_o),
        .mem_ack_i     (mem_ack_i),
        .beat_valid_i  (beat_valid_i),
        .beat_data_i   (beat_data_i)
    );

endmodule

`default_nettype wire

// File: verilog/icache_way.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way (
    input  logic                                        clk,
    input  logic                                        reset,
    input  cache_geom_pkg::index_t                      raddr_i,
    input  cache_geom_pkg::tag_t                        tag_i,
    input  logic                                        we_i,
    input  cache_geom_pkg::index_t                      waddr_i,
    input  cache_geom_pkg::line_t                       line_i,
    input  cache_geom_pkg::tagv_t                       tagv_i,
    input  logic [$clog2(cache_geom_pkg::bank_num)-1:0] word_sel_i,
    output logic                                        hit_o,
    output logic [31:0]                                 word_o
);
    import cache_geom_pkg::*;

    logic [31:0] bank_q [bank_num];
    tagv_t       tagv_q;

    for (genvar b = 0; b < bank_num; b++) begin : g_bank
        sdp_ram #(
            .word_t (logic [31:0]),
            .depth  (set_num)
        ) u_bank (
            .clk     (clk),
            .reset   (reset),
            .we_i    (we_i),
            .waddr_i (waddr_i),
            .wdata_i (line_i[b]),
            .raddr_i (raddr_i),
            .rdata_o (bank_q[b])
        );
    end

    sdp_ram #(
        .word_t (tagv_t),
        .depth  (set_num)
    ) u_tagv (
        .clk     (clk),
        .reset   (reset),
        .we_i    (we_i),
        .waddr_i (waddr_i),
        .wdata_i (tagv_i),
        .raddr_i (raddr_i),
        .rdata_o (tagv_q)
    );

    // tag_i is the lookup that issued this read last cycle
    assign hit_o  = tagv_q.valid && (tagv_q.tag == tag_i);
    assign word_o = bank_q[word_sel_i];

    a_we_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(we_i));

endmodule

`default_nettype wire

// File: verilog/sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
    parameter type word_t = logic [31:0],
    parameter int  depth  = 128
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we_i,
    input  logic [$clog2(depth)-1:0] waddr_i,
    input  word_t                    wdata_i,
    input  logic [$clog2(depth)-1:0] raddr_i,
    output word_t                    rdata_o
);

    word_t mem [depth];

    // contents come up cleared, so every tag starts invalid
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // same-address collision reads the old word
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire
